//--- axi_regs_stim.txt
# columns: op  addr_or_index  data  expected_data  expected_flag (bresp or fresh bit)
# ops: pw pwa pwd wc = bus write, pr = bus read, rand = write and read back, rw rr rc = rtl side
pr   00 0000 0102 0
pr   04 0000 0008 0
pr   08 0000 0040 0
pr   14 0000 0000 0
rand 5  0000 0000 0
rand 6  0000 0000 0
rand 7  0000 0000 0
pw   0c 0100 0000 0
pr   0c 0000 0040 0
pw   0c 0020 0000 0
pr   0c 0000 0020 0
pw   10 00ff 0000 0
pr   10 0000 000c 0
rw   4  0030 0000 1
pr   10 0000 000c 0
rw   3  0041 0000 1
pr   0c 0000 0040 0
pw   00 ffff 0000 0
pr   00 0000 0102 0
rw   1  1234 0000 0
pr   04 0000 0008 0
rw   2  0001 0000 0
pr   08 0000 0040 0
pw   20 dead 0000 2
pw   15 beef 0000 2
pr   20 0000 0000 0
pr   1e 0000 0000 0
pwa  14 a5a5 0000 0
pwd  18 5a5a 0000 0
pr   14 0000 a5a5 0
pr   18 0000 5a5a 0
rw   7  c3c3 0000 1
pr   1c 0000 c3c3 0
rr   7  0000 c3c3 0
pw   14 1111 0000 0
rr   5  0000 1111 0
rc   6  7777 5a5a 1
rr   6  0000 7777 0
wc   1c 2222 3333 0
pr   1c 0000 2222 0

//--- axi_regs.f
+incdir+.
axi_pkg.sv
reg_map_pkg.sv
axi_write_accept.sv
axi_reg_file.sv
axi_read_return.sv
axi_regs_top.sv
axi_regs_sva.sv
axi_regs_tb.sv

//--- Makefile
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert --top-module axi_regs_tb -f axi_regs.f -o axi_regs_sim
	@out="$$(./obj_dir/axi_regs_sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "RESULT: PASS"

clean:
	rm -rf obj_dir

//--- axi_regs_tb.sv
`timescale 1ns/1ns
`include "axi_regs_cfg.svh"

module axi_regs_tb;

	logic clk;
	logic rst_n;
	logic awvalid;
	axi_pkg::addr_t awaddr;
	logic awready;
	logic wvalid;
	axi_pkg::data_t wdata;
	logic wready;
	logic bvalid;
	logic bready;
	axi_pkg::resp_t bresp;
	logic arvalid;
	axi_pkg::addr_t araddr;
	logic arready;
	logic rvalid;
	logic rready;
	axi_pkg::data_t rdata;
	reg_map_pkg::reg_vec_t rtl_write_reqs;
	reg_map_pkg::reg_data_t rtl_wd_in;
	reg_map_pkg::reg_vec_t rtl_read_reqs;
	reg_map_pkg::reg_data_t rtl_rd_out;
	reg_map_pkg::reg_vec_t fresh_bits;

	// one entry per stimulus line
	string op_q[$];
	logic [31:0] arg_q[$];
	logic [31:0] data_q[$];
	logic [31:0] exp_data_q[$];
	logic [31:0] exp_flag_q[$];

	logic [31:0] seed;
	int checks;
	int errors;
	int cycles;
	int limit;

	axi_regs_top dut (
		.clk(clk), .rst_n(rst_n),
		.awvalid(awvalid), .awready(awready), .awaddr(awaddr),
		.wvalid(wvalid), .wready(wready), .wdata(wdata),
		.bvalid(bvalid), .bready(bready), .bresp(bresp),
		.arvalid(arvalid), .arready(arready), .araddr(araddr),
		.rvalid(rvalid), .rready(rready), .rdata(rdata),
		.rtl_write_reqs(rtl_write_reqs), .rtl_wd_in(rtl_wd_in),
		.rtl_read_reqs(rtl_read_reqs), .rtl_rd_out(rtl_rd_out),
		.fresh_bits(fresh_bits)
	);

	bind axi_regs_top axi_regs_sva u_sva (
		.clk(clk), .rst_n(rst_n),
		.bvalid(bvalid), .bready(bready), .bresp(bresp),
		.rvalid(rvalid), .rready(rready), .rdata(rdata),
		.arready(arready), .fresh_bits(fresh_bits)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function logic [31:0] next_rand();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	task check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail %s: got %h, expected %h at %0t", name, got, exp, $time);
		end
	endtask

	task next_edge();
		@(posedge clk);
		#5; // inputs change a little after the edge
	endtask

	task automatic load_stimulus();
		int fd;
		int n;
		string line;
		string op;
		logic [31:0] a, d, e, f;
		fd = $fopen("axi_regs_stim.txt", "r");
		if (fd != 0) begin
			while (!$feof(fd)) begin
				line = "";
				void'($fgets(line, fd));
				n = $sscanf(line, "%s %h %h %h %h", op, a, d, e, f);
				if (n == 5 && op.getc(0) != "#") begin
					op_q.push_back(op);
					arg_q.push_back(a);
					data_q.push_back(d);
					exp_data_q.push_back(e);
					exp_flag_q.push_back(f);
				end
			end
			$fclose(fd);
		end
	endtask

	// mode 0 sends both channels together, 1 the address first, 2 the data first
	task automatic ps_write(input logic [31:0] addr, input logic [31:0] data, input int mode,
			input int gap, input logic [31:0] exp_resp, input bit clash,
			input logic [31:0] rtl_data);
		int aw_wait;
		int w_wait;
		int idx;
		bit aw_done;
		bit w_done;
		bit b_done;
		logic [31:0] r;
		aw_wait = (mode == 2) ? gap : 0;
		w_wait = (mode == 1) ? gap : 0;
		aw_done = 1'b0;
		w_done = 1'b0;
		b_done = 1'b0;
		idx = int'(addr[4:2]);
		awaddr = addr[`AXI_ADDR_W-1:0];
		wdata = data[`DATA_W-1:0];
		while (!(aw_done && w_done)) begin
			awvalid = !aw_done && (aw_wait == 0);
			wvalid = !w_done && (w_wait == 0);
			@(negedge clk);
			if (bvalid) begin
				errors++;
				$display("write response appeared before address and data were both accepted");
			end
			if (awvalid && awready)
				aw_done = 1'b1;
			if (wvalid && wready)
				w_done = 1'b1;
			if (aw_wait > 0)
				aw_wait--;
			if (w_wait > 0)
				w_wait--;
			next_edge();
		end
		awvalid = 1'b0;
		wvalid = 1'b0;
		// the processor word lands two edges after the later handshake
		if (clash) begin
			next_edge();
			rtl_write_reqs[idx] = 1'b1;
			rtl_wd_in[idx] = rtl_data[`DATA_W-1:0];
			next_edge();
			rtl_write_reqs = '0;
		end
		while (!b_done) begin
			r = next_rand();
			bready = r[17:16] != 2'b00;
			@(negedge clk);
			if (bvalid && bready) begin
				b_done = 1'b1;
				check_value("bresp", 32'(bresp), exp_resp);
			end
			next_edge();
		end
		bready = 1'b0;
		check_value("bvalid", 32'(bvalid), 32'd0); // exactly one response per write
	endtask

	task automatic ps_read(input logic [31:0] addr, input logic [31:0] exp_data,
			input logic [31:0] exp_fresh);
		bit ar_done;
		bit r_done;
		int idx;
		logic [31:0] r;
		ar_done = 1'b0;
		r_done = 1'b0;
		idx = int'(addr[4:2]);
		araddr = addr[`AXI_ADDR_W-1:0];
		arvalid = 1'b1;
		while (!ar_done) begin
			@(negedge clk);
			if (arready)
				ar_done = 1'b1;
			next_edge();
		end
		arvalid = 1'b0;
		while (!r_done) begin
			r = next_rand();
			rready = r[21:20] != 2'b00;
			@(negedge clk);
			if (rvalid && rready) begin
				r_done = 1'b1;
				check_value("rdata", 32'(rdata), exp_data);
			end
			next_edge();
		end
		rready = 1'b0;
		check_value("rvalid", 32'(rvalid), 32'd0);
		// a bus read leaves the fresh bit of the register it addressed cleared
		check_value($sformatf("fresh_bits[%0d]", idx), 32'(fresh_bits[idx]), exp_fresh);
	endtask

	// write and read on the same edge when both flags are set
	task automatic rtl_access(input int idx, input bit wr, input bit rd, input logic [31:0] data,
			input logic [31:0] exp_data, input logic [31:0] exp_fresh);
		rtl_write_reqs[idx] = wr;
		rtl_read_reqs[idx] = rd;
		rtl_wd_in[idx] = data[`DATA_W-1:0];
		next_edge();
		rtl_write_reqs = '0;
		rtl_read_reqs = '0;
		if (rd)
			check_value($sformatf("rtl_rd_out[%0d]", idx), 32'(rtl_rd_out[idx]), exp_data);
		check_value($sformatf("fresh_bits[%0d]", idx), 32'(fresh_bits[idx]), exp_fresh);
	endtask

	task automatic run_op(input int i);
		string op;
		logic [31:0] a, d, e, f, r, rnd_data;
		int mode;
		int gap;
		int idx;
		op = op_q[i];
		a = arg_q[i];
		d = data_q[i];
		e = exp_data_q[i];
		f = exp_flag_q[i];
		r = next_rand();
		mode = int'(r[1:0]) % 3;
		gap = int'(r[6:4]);
		idx = int'(a[2:0]);
		if (op == "pw")
			ps_write(a, d, mode, gap, f, 1'b0, 32'd0);
		else if (op == "pwa")
			ps_write(a, d, 1, 12, f, 1'b0, 32'd0);
		else if (op == "pwd")
			ps_write(a, d, 2, 12, f, 1'b0, 32'd0);
		else if (op == "wc")
			ps_write(a, d, 0, 0, f, 1'b1, e);
		else if (op == "pr")
			ps_read(a, e, f);
		else if (op == "rand") begin
			rnd_data = next_rand() >> 16;
			ps_write(idx * 4, rnd_data, mode, gap, 32'd0, 1'b0, 32'd0);
			ps_read(idx * 4, rnd_data, 32'd0); // a general register keeps what was written
		end else if (op == "rw")
			rtl_access(idx, 1'b1, 1'b0, d, 32'd0, f);
		else if (op == "rr")
			rtl_access(idx, 1'b0, 1'b1, 32'd0, e, f);
		else if (op == "rc")
			rtl_access(idx, 1'b1, 1'b1, d, e, f);
		else begin
			errors++;
			$display("unknown operation %s on stimulus entry %0d", op, i);
		end
	endtask

	initial begin
		cycles = 0;
		wait (limit > 0);
		while (cycles < limit) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout after %0d cycles, the operations did not complete", limit);
		$display("RESULT: FAIL");
		$finish;
	end

	initial begin
		rst_n = 1'b0;
		awvalid = 1'b0;
		awaddr = '0;
		wvalid = 1'b0;
		wdata = '0;
		bready = 1'b0;
		arvalid = 1'b0;
		araddr = '0;
		rready = 1'b0;
		rtl_write_reqs = '0;
		rtl_wd_in = '0;
		rtl_read_reqs = '0;
		seed = 32'h93fa_f1f2;
		checks = 0;
		errors = 0;
		load_stimulus();
		if (op_q.size() == 0) begin
			errors++;
			$display("the stimulus file could not be read or holds no operations");
		end
		limit = 40 * op_q.size() + 200;
		repeat (16) @(posedge clk);
		#5;
		rst_n = 1'b1;
		check_value("awready", 32'(awready), 32'd1);
		check_value("wready", 32'(wready), 32'd1);
		check_value("arready", 32'(arready), 32'd1);
		check_value("bvalid", 32'(bvalid), 32'd0);
		check_value("rvalid", 32'(rvalid), 32'd0);
		check_value("fresh_bits", 32'(fresh_bits), 32'd0);
		for (int i = 0; i < op_q.size(); i++)
			run_op(i);
		next_edge();
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

//--- axi_regs_sva.sv
`timescale 1ns/1ns
`include "axi_regs_cfg.svh"

module axi_regs_sva (
	input logic                  clk,
	input logic                  rst_n,
	input logic                  bvalid,
	input logic                  bready,
	input axi_pkg::resp_t        bresp,
	input logic                  rvalid,
	input logic                  rready,
	input axi_pkg::data_t        rdata,
	input logic                  arready,
	input reg_map_pkg::reg_vec_t fresh_bits
);

	// a pending response waits for the master without changing
	b_hold: assert property (@(posedge clk) disable iff (!rst_n)
		bvalid && !bready |=> bvalid && $stable(bresp))
		else $error("bvalid or bresp changed while bready was low");

	r_hold: assert property (@(posedge clk) disable iff (!rst_n)
		rvalid && !rready |=> rvalid && $stable(rdata))
		else $error("rvalid or rdata changed while rready was low");

	ar_blocked: assert property (@(posedge clk) disable iff (!rst_n)
		rvalid |-> !arready) // one read in flight at a time
		else $error("arready high while read data was pending");

	ro_not_fresh: assert property (@(posedge clk) disable iff (!rst_n)
		!fresh_bits[`VERSION_ID] && !fresh_bits[`MEM_SIZE_ID] &&
		!fresh_bits[`MAX_BURST_SIZE_ID])
		else $error("a read-only register shows a fresh bit");

endmodule

//--- axi_regs_top.sv
`timescale 1ns/1ns
`include "axi_regs_cfg.svh"

module axi_regs_top (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   awvalid,
	output logic                   awready,
	input  axi_pkg::addr_t         awaddr,
	input  logic                   wvalid,
	output logic                   wready,
	input  axi_pkg::data_t         wdata,
	output logic                   bvalid,
	input  logic                   bready,
	output axi_pkg::resp_t         bresp,
	input  logic                   arvalid,
	output logic                   arready,
	input  axi_pkg::addr_t         araddr,
	output logic                   rvalid,
	input  logic                   rready,
	output axi_pkg::data_t         rdata,
	input  reg_map_pkg::reg_vec_t  rtl_write_reqs,
	input  reg_map_pkg::reg_data_t rtl_wd_in,
	input  reg_map_pkg::reg_vec_t  rtl_read_reqs,
	output reg_map_pkg::reg_data_t rtl_rd_out,
	output reg_map_pkg::reg_vec_t  fresh_bits
);

	// write command into storage
	logic wr_valid;
	reg_map_pkg::reg_id_t wr_id;
	axi_pkg::data_t wr_data;

	// read command and the word coming back
	logic rd_valid;
	reg_map_pkg::reg_id_t rd_id;
	axi_pkg::data_t rd_data;

	axi_write_accept u_write (
		.clk(clk), .rst_n(rst_n),
		.awvalid(awvalid), .awaddr(awaddr), .awready(awready),
		.wvalid(wvalid), .wdata(wdata), .wready(wready),
		.bready(bready), .bvalid(bvalid), .bresp(bresp),
		.wr_valid(wr_valid), .wr_id(wr_id), .wr_data(wr_data)
	);

	axi_reg_file u_regs (
		.clk(clk), .rst_n(rst_n),
		.wr_valid(wr_valid), .wr_id(wr_id), .wr_data(wr_data),
		.rd_valid(rd_valid), .rd_id(rd_id), .rd_data(rd_data),
		.rtl_write_reqs(rtl_write_reqs),
		.rtl_read_reqs(rtl_read_reqs),
		.rtl_wd_in(rtl_wd_in),
		.rtl_rd_out(rtl_rd_out),
		.fresh_bits(fresh_bits)
	);

	axi_read_return u_read (
		.clk(clk), .rst_n(rst_n),
		.arvalid(arvalid), .araddr(araddr), .arready(arready),
		.rready(rready), .rvalid(rvalid), .rdata(rdata),
		.rd_valid(rd_valid), .rd_id(rd_id),
		.rd_data(rd_data)
	);

endmodule

//--- axi_read_return.sv
`timescale 1ns/1ns
`include "axi_regs_cfg.svh"

module axi_read_return (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 arvalid,
	input  axi_pkg::addr_t       araddr,
	output logic                 arready,
	input  logic                 rready,
	output logic                 rvalid,
	output axi_pkg::data_t       rdata,
	output logic                 rd_valid,
	output reg_map_pkg::reg_id_t rd_id,
	input  axi_pkg::data_t       rd_data
);

	logic busy; // from the ar handshake until the r handshake
	logic fetch; // one cycle after any accepted read, in range or not
	logic ar_fire;
	logic r_fire;

	assign arready = !busy;
	assign ar_fire = arvalid && arready;
	assign r_fire = rvalid && rready;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy <= 1'b0;
			fetch <= 1'b0;
			rd_valid <= 1'b0;
			rvalid <= 1'b0;
		end else begin
			fetch <= ar_fire;
			// an out-of-range read must not touch a fresh bit
			rd_valid <= ar_fire && reg_map_pkg::addr_in_range(araddr);

			if (ar_fire)
				busy <= 1'b1;
			else if (r_fire)
				busy <= 1'b0;

			if (fetch)
				rvalid <= 1'b1;
			else if (r_fire)
				rvalid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (ar_fire)
			rd_id <= reg_map_pkg::addr_to_id(araddr);
		if (fetch)
			rdata <= rd_valid ? rd_data : '0; // rd_valid low here marks a rejected address
	end

endmodule

//--- axi_reg_file.sv
`timescale 1ns/1ns
`include "axi_regs_cfg.svh"

module axi_reg_file (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   wr_valid,
	input  reg_map_pkg::reg_id_t   wr_id,
	input  axi_pkg::data_t         wr_data,
	input  logic                   rd_valid,
	input  reg_map_pkg::reg_id_t   rd_id,
	output axi_pkg::data_t         rd_data,
	input  reg_map_pkg::reg_vec_t  rtl_write_reqs,
	input  reg_map_pkg::reg_vec_t  rtl_read_reqs,
	input  reg_map_pkg::reg_data_t rtl_wd_in,
	output reg_map_pkg::reg_data_t rtl_rd_out,
	output reg_map_pkg::reg_vec_t  fresh_bits
);

	reg_map_pkg::reg_data_t mem_q;
	reg_map_pkg::reg_data_t wr_next; // clamped word each register would take
	reg_map_pkg::reg_vec_t ps_wr; // processor write aimed at this register
	reg_map_pkg::reg_vec_t wr_en;
	reg_map_pkg::reg_vec_t rd_hit; // read from either side this cycle

	function automatic logic is_read_only(int idx);
		return idx == `VERSION_ID || idx == `MEM_SIZE_ID || idx == `MAX_BURST_SIZE_ID;
	endfunction

	// the two tunable registers saturate at their limit
	function automatic axi_pkg::data_t clamp_value(int idx, axi_pkg::data_t d);
		if (idx == `BURST_SIZE_ID && d > `MAX_BURST_SIZE)
			return axi_pkg::data_t'(`MAX_BURST_SIZE);
		if (idx == `SCALE_FACTOR_ID && d > `MAX_SCALE_FACTOR)
			return axi_pkg::data_t'(`MAX_SCALE_FACTOR);
		return d;
	endfunction

	// read-only registers come out of reset holding their constant and are never written
	function automatic axi_pkg::data_t reset_value(int idx);
		case (idx)
			`VERSION_ID: return `FIRMWARE_VERSION;
			`MEM_SIZE_ID: return axi_pkg::data_t'(`MEM_SIZE);
			`MAX_BURST_SIZE_ID: return axi_pkg::data_t'(`MAX_BURST_SIZE);
			default: return '0;
		endcase
	endfunction

	always_comb begin
		for (int i = 0; i < `MEM_SIZE; i++) begin
			ps_wr[i] = wr_valid && (wr_id == reg_map_pkg::reg_id_t'(i));
			wr_en[i] = (ps_wr[i] || rtl_write_reqs[i]) && !is_read_only(i);
			wr_next[i] = clamp_value(i, ps_wr[i] ? wr_data : rtl_wd_in[i]); // processor side wins
			rd_hit[i] = (rd_valid && (rd_id == reg_map_pkg::reg_id_t'(i))) || rtl_read_reqs[i];
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `MEM_SIZE; i++)
				mem_q[i] <= reset_value(i);
			fresh_bits <= '0;
		end else begin
			for (int i = 0; i < `MEM_SIZE; i++) begin
				// a write on the same edge as a read keeps the bit set
				if (wr_en[i]) begin
					mem_q[i] <= wr_next[i];
					fresh_bits[i] <= 1'b1;
				end else if (rd_hit[i]) begin
					fresh_bits[i] <= 1'b0;
				end
			end
		end
	end

	// rtl reads pick up the word from before the edge
	always_ff @(posedge clk) begin
		for (int i = 0; i < `MEM_SIZE; i++) begin
			if (rtl_read_reqs[i])
				rtl_rd_out[i] <= mem_q[i];
		end
	end

	assign rd_data = mem_q[rd_id]; // sampled by the read stage on the edge after rd_valid

endmodule

//--- axi_write_accept.sv
`timescale 1ns/1ns
`include "axi_regs_cfg.svh"

module axi_write_accept (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 awvalid,
	input  axi_pkg::addr_t       awaddr,
	output logic                 awready,
	input  logic                 wvalid,
	input  axi_pkg::data_t       wdata,
	output logic                 wready,
	input  logic                 bready,
	output logic                 bvalid,
	output axi_pkg::resp_t       bresp,
	output logic                 wr_valid,
	output reg_map_pkg::reg_id_t wr_id,
	output axi_pkg::data_t       wr_data
);

	logic aw_held; // address captured, still waiting for its data word
	logic w_held; // data captured, still waiting for its address
	axi_pkg::addr_t addr_q;
	axi_pkg::data_t data_q;
	logic aw_fire;
	logic w_fire;
	logic b_fire;
	logic issue;
	logic addr_ok;

	assign awready = !aw_held;
	assign wready = !w_held;

	assign aw_fire = awvalid && awready;
	assign w_fire = wvalid && wready;
	assign b_fire = bvalid && bready;

	// a pair only goes out once the previous response has been taken
	assign issue = aw_held && w_held && !bvalid;
	assign addr_ok = reg_map_pkg::addr_in_range(addr_q);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			aw_held <= 1'b0;
			w_held <= 1'b0;
			bvalid <= 1'b0;
			bresp <= axi_pkg::RESP_OKAY;
			wr_valid <= 1'b0;
		end else begin
			wr_valid <= issue && addr_ok; // a rejected address never reaches storage

			if (aw_fire)
				aw_held <= 1'b1;
			else if (issue)
				aw_held <= 1'b0;

			if (w_fire)
				w_held <= 1'b1;
			else if (issue)
				w_held <= 1'b0;

			// issue needs bvalid low, so the two branches never meet
			if (issue) begin
				bvalid <= 1'b1;
				bresp <= addr_ok ? axi_pkg::RESP_OKAY : axi_pkg::RESP_SLVERR;
			end else if (b_fire) begin
				bvalid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (aw_fire)
			addr_q <= awaddr;
		if (w_fire)
			data_q <= wdata;

		// the command carries the index, the byte offset is already checked
		if (issue) begin
			wr_id <= reg_map_pkg::addr_to_id(addr_q);
			wr_data <= data_q;
		end
	end

endmodule

//--- reg_map_pkg.sv
`include "axi_regs_cfg.svh"

package reg_map_pkg;

	typedef logic [$clog2(`MEM_SIZE)-1:0] reg_id_t;
	typedef logic [`MEM_SIZE-1:0] reg_vec_t; // one bit per register
	typedef axi_pkg::data_t [`MEM_SIZE-1:0] reg_data_t;

	// word aligned and inside the register map
	function automatic logic addr_in_range(axi_pkg::addr_t a);
		return (a[1:0] == 2'b00) && (a[`AXI_ADDR_W-1:2] < `MEM_SIZE);
	endfunction

	function automatic reg_id_t addr_to_id(axi_pkg::addr_t a);
		return a[2 +: $clog2(`MEM_SIZE)];
	endfunction

endpackage

//--- axi_pkg.sv
`include "axi_regs_cfg.svh"

package axi_pkg;

	typedef logic [`AXI_ADDR_W-1:0] addr_t; // byte address on the bus
	typedef logic [`DATA_W-1:0] data_t;

	// only the two codes this slave ever returns
	typedef enum logic [1:0] {
		RESP_OKAY = 2'b00,
		RESP_SLVERR = 2'b10
	} resp_t;

endpackage

//--- axi_regs_cfg.svh
`ifndef AXI_REGS_CFG_SVH
`define AXI_REGS_CFG_SVH

// bus and register widths
`define AXI_ADDR_W 8
`define DATA_W 16
`define MEM_SIZE 8

// register indices, the byte address is the index times 4
`define VERSION_ID 0
`define MEM_SIZE_ID 1
`define MAX_BURST_SIZE_ID 2
`define BURST_SIZE_ID 3
`define SCALE_FACTOR_ID 4

// values of the read-only registers
`define FIRMWARE_VERSION 16'h0102
`define MAX_BURST_SIZE 64

// writes above this are stored as the limit
`define MAX_SCALE_FACTOR 12

`endif
